//--- common/wbsoc_params.svh
// Wishbone subsystem constants
// Block select bytes, sort register offsets, sort sizing and
// scratch memory sizing and latency
`ifndef WBSOC_PARAMS_SVH
`define WBSOC_PARAMS_SVH

//------------------------------------------------------------
// Address decode, top byte of the bus address
//------------------------------------------------------------
`define WB_SORT_SEL 8'h33
`define WB_MEM_SEL 8'h38

//------------------------------------------------------------
// Sort block register map, byte offsets in the low byte
//------------------------------------------------------------
`define SORT_CTRL_OFS 8'h00
`define SORT_SLOT_OFS 8'h10
`define SORT_RES_OFS 8'h38

// Slot count and network steps, two levels per step
`define SORT_N 10
`define SORT_STEPS 5

//------------------------------------------------------------
// Scratch memory
//------------------------------------------------------------
`define MEM_DEPTH 256
// Ack delay in cycles after the request is presented
`define MEM_DELAY 2

`endif

//--- common/wbsoc_pkg.sv
// Shared types for the Wishbone subsystem
// Bus word, sort array and the sort controller states
`default_nettype none

`include "wbsoc_params.svh"

package wbsoc_pkg;

    //------------------------------------------------------------
    // Bus payload
    //------------------------------------------------------------
    typedef logic [31:0] word_t;

    // All sort slots side by side, index 0 is the lowest slot
    typedef word_t [`SORT_N-1:0] sort_array_t;

    //------------------------------------------------------------
    // Sort controller FSM
    //------------------------------------------------------------
    // Idle waits for a start, load copies the slots into the
    // network, step runs the comparator levels
    typedef enum logic [1:0] {
        sort_idle = 2'd0,
        sort_load = 2'd1,
        sort_step = 2'd2
    } sort_state_e;

endpackage

`default_nettype wire

//--- source/wb_bus_split.sv
// Wishbone address decoder and response merge
// Routes strobes by the top address byte and folds the block
// acks and read data back onto the master bus
`timescale 1ns/10ps
`default_nettype none

`include "wbsoc_params.svh"

module wb_bus_split
    import wbsoc_pkg::*;
(
    input  wire   wbs_stb_i,
    input  wire   wbs_cyc_i,
    input  word_t wbs_adr_i,
    output logic  sort_stb_o,
    output logic  mem_stb_o,
    input  wire   sort_ack_i,
    input  wire   mem_ack_i,
    input  word_t sort_dat_i,
    input  word_t mem_dat_i,
    output logic  wbs_ack_o,
    output word_t wbs_dat_o
);

    logic       bus_req;
    logic [7:0] blk_sel;

    //------------------------------------------------------------
    // Request decode
    //------------------------------------------------------------
    assign bus_req = wbs_stb_i & wbs_cyc_i;
    assign blk_sel = wbs_adr_i[31:24];

    // Unmapped bytes reach no block and stay unacked
    assign sort_stb_o = bus_req && (blk_sel == `WB_SORT_SEL);
    assign mem_stb_o  = bus_req && (blk_sel == `WB_MEM_SEL);

    //------------------------------------------------------------
    // Response merge
    //------------------------------------------------------------
    assign wbs_ack_o = sort_ack_i | mem_ack_i;

    always_comb begin
        // Sort first, zero when nobody acks
        if (sort_ack_i) begin
            wbs_dat_o = sort_dat_i;
        end else if (mem_ack_i) begin
            wbs_dat_o = mem_dat_i;
        end else begin
            wbs_dat_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- sort/sort_network.sv
// Odd-even transposition sort network
// Holds the working array and applies two comparator levels per step,
// even pairs then odd pairs, smaller value to the lower index
`timescale 1ns/10ps
`default_nettype none

`include "wbsoc_params.svh"

module sort_network
    import wbsoc_pkg::*;
(
    input  wire         wb_clk_i,
    input  wire         wb_rst_i,
    input  wire         load_i,
    input  wire         step_i,
    input  sort_array_t slots_i,
    output sort_array_t sorted_o
);

    sort_array_t lv0;
    sort_array_t lv1;

    //------------------------------------------------------------
    // Two comparator levels
    //------------------------------------------------------------
    always_comb begin
        lv0 = sorted_o;
        // Even level, pairs (0,1) (2,3) ...
        for (int i = 0; i + 1 < `SORT_N; i += 2) begin
            if (sorted_o[i] > sorted_o[i+1]) begin
                lv0[i]   = sorted_o[i+1];
                lv0[i+1] = sorted_o[i];
            end
        end
        lv1 = lv0;
        // Odd level, pairs (1,2) (3,4) ...
        for (int i = 1; i + 1 < `SORT_N; i += 2) begin
            if (lv0[i] > lv0[i+1]) begin
                lv1[i]   = lv0[i+1];
                lv1[i+1] = lv0[i];
            end
        end
    end

    // Working array
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sorted_o <= '0;
        end else if (load_i) begin
            sorted_o <= slots_i;
        end else if (step_i) begin
            sorted_o <= lv1;
        end
    end

endmodule

`default_nettype wire

//--- sort/sort_ctrl.sv
// Sort accelerator register block
// Slot registers, start and done status, the FSM that sequences the
// comparator network, and the single-cycle bus responses
`timescale 1ns/10ps
`default_nettype none

`include "wbsoc_params.svh"

module sort_ctrl
    import wbsoc_pkg::*;
(
    input  wire         wb_clk_i,
    input  wire         wb_rst_i,
    input  wire         stb_i,
    input  wire         we_i,
    input  wire  [7:0]  adr_i,
    input  word_t       dat_i,
    output logic        ack_o,
    output word_t       dat_o,
    output logic        load_o,
    output logic        step_o,
    output sort_array_t slots_o,
    input  sort_array_t sorted_i
);

    localparam int IDX_W = $clog2(`SORT_N);
    localparam int CNT_W = $clog2(`SORT_STEPS);
    localparam logic [CNT_W-1:0] STEP_LAST = CNT_W'(`SORT_STEPS - 1);

    // Word offsets within the block
    localparam logic [5:0] CTRL_W = 6'(`SORT_CTRL_OFS >> 2);
    localparam logic [5:0] SLOT_W = 6'(`SORT_SLOT_OFS >> 2);
    localparam logic [5:0] RES_W  = 6'(`SORT_RES_OFS >> 2);
    localparam logic [5:0] N_W    = 6'(`SORT_N);

    sort_state_e      state;
    logic [CNT_W-1:0] step_cnt;
    logic             done;
    logic             take;
    logic [5:0]       word_a;
    logic [5:0]       slot_k;
    logic [5:0]       res_k;
    logic             ctrl_hit;
    logic             slot_hit;
    logic             res_hit;
    logic             slot_wr;
    logic             start;
    word_t            rd_data;

    //------------------------------------------------------------
    // Access decode
    //------------------------------------------------------------
    // One access per strobe, the ack cycle never counts twice
    assign take   = stb_i & ~ack_o;
    assign word_a = adr_i[7:2];
    assign slot_k = word_a - SLOT_W;
    assign res_k  = word_a - RES_W;

    assign ctrl_hit = (word_a == CTRL_W);
    assign slot_hit = (word_a >= SLOT_W) && (word_a < SLOT_W + N_W);
    assign res_hit  = (word_a >= RES_W) && (word_a < RES_W + N_W);

    assign slot_wr = take && we_i && slot_hit;
    assign start   = take && we_i && ctrl_hit && dat_i[0];

    always_comb begin
        rd_data = '0;
        if (ctrl_hit) begin
            rd_data = {31'd0, done};
        end else if (slot_hit) begin
            rd_data = slots_o[slot_k[IDX_W-1:0]];
        end else if (res_hit) begin
            rd_data = sorted_i[res_k[IDX_W-1:0]];
        end
    end

    //------------------------------------------------------------
    // Bus response
    //------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= take;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (take) begin
            dat_o <= rd_data;
        end
    end

    // Slot registers
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            slots_o <= '0;
        end else if (slot_wr) begin
            slots_o[slot_k[IDX_W-1:0]] <= dat_i;
        end
    end

    //------------------------------------------------------------
    // Sort sequencing
    //------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state    <= sort_idle;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            case (state)
                sort_load: begin
                    state    <= sort_step;
                    step_cnt <= '0;
                end
                sort_step: begin
                    if (step_cnt == STEP_LAST) begin
                        state <= sort_idle;
                        done  <= 1'b1;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                default: state <= sort_idle;
            endcase
            // Slot writes invalidate the last result
            if (slot_wr) begin
                done <= 1'b0;
            end
            // A start restarts even a running sort
            if (start) begin
                state <= sort_load;
                done  <= 1'b0;
            end
        end
    end

    assign load_o = (state == sort_load);
    assign step_o = (state == sort_step);

endmodule

`default_nettype wire

//--- exmem/exmem_ram.sv
// Scratch memory with fixed access latency
// Word array addressed by bus address bits above the byte lane,
// ack raised a fixed number of cycles after each request
`timescale 1ns/10ps
`default_nettype none

`include "wbsoc_params.svh"

module exmem_ram
    import wbsoc_pkg::*;
(
    input  wire   wb_clk_i,
    input  wire   wb_rst_i,
    input  wire   stb_i,
    input  wire   we_i,
    input  word_t adr_i,
    input  word_t dat_i,
    output logic  ack_o,
    output word_t dat_o
);

    localparam int AW    = $clog2(`MEM_DEPTH);
    localparam int CNT_W = $clog2(`MEM_DELAY + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MEM_DELAY - 1);

    word_t          mem [`MEM_DEPTH];
    logic [CNT_W-1:0] cnt;
    logic [AW-1:0]  idx;
    logic           fire;

    // Higher address bits alias onto the same words
    assign idx  = adr_i[AW+1:2];
    // Last delay cycle of a pending request
    assign fire = stb_i && !ack_o && (cnt == CNT_LAST);

    //------------------------------------------------------------
    // Delay counter, ack and write
    //------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_o <= 1'b0;
            cnt   <= '0;
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ack_o <= fire;
            if (ack_o || !stb_i || fire) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            if (fire && we_i) begin
                mem[idx] <= dat_i;
            end
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge wb_clk_i) begin
        if (fire) begin
            dat_o <= mem[idx];
        end
    end

endmodule

`default_nettype wire

//--- source/user_project_wrapper.sv
// Wishbone slave subsystem top
// Bus split in front of the sort accelerator and the scratch memory,
// responses merged back onto one ack and data bus
`timescale 1ns/10ps
`default_nettype none

module user_project_wrapper
    import wbsoc_pkg::*;
(
    input  wire   wb_clk_i,
    input  wire   wb_rst_i,
    input  wire   wbs_stb_i,
    input  wire   wbs_cyc_i,
    input  wire   wbs_we_i,
    input  word_t wbs_adr_i,
    input  word_t wbs_dat_i,
    output logic  wbs_ack_o,
    output word_t wbs_dat_o
);

    // Per-block strobes and responses
    logic        sort_stb;
    logic        sort_ack;
    word_t       sort_dat;
    logic        mem_stb;
    logic        mem_ack;
    word_t       mem_dat;

    // Sort controller to network
    logic        sort_load;
    logic        sort_step;
    sort_array_t sort_slots;
    sort_array_t sort_sorted;

    wb_bus_split bus_split_i (
        .wbs_stb_i  (wbs_stb_i),
        .wbs_cyc_i  (wbs_cyc_i),
        .wbs_adr_i  (wbs_adr_i),
        .sort_stb_o (sort_stb),
        .mem_stb_o  (mem_stb),
        .sort_ack_i (sort_ack),
        .mem_ack_i  (mem_ack),
        .sort_dat_i (sort_dat),
        .mem_dat_i  (mem_dat),
        .wbs_ack_o  (wbs_ack_o),
        .wbs_dat_o  (wbs_dat_o)
    );

    sort_ctrl sort_ctrl_i (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .stb_i    (sort_stb),
        .we_i     (wbs_we_i),
        .adr_i    (wbs_adr_i[7:0]),
        .dat_i    (wbs_dat_i),
        .ack_o    (sort_ack),
        .dat_o    (sort_dat),
        .load_o   (sort_load),
        .step_o   (sort_step),
        .slots_o  (sort_slots),
        .sorted_i (sort_sorted)
    );

    sort_network sort_network_i (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .load_i   (sort_load),
        .step_i   (sort_step),
        .slots_i  (sort_slots),
        .sorted_o (sort_sorted)
    );

    exmem_ram exmem_ram_i (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .stb_i    (mem_stb),
        .we_i     (wbs_we_i),
        .adr_i    (wbs_adr_i),
        .dat_i    (wbs_dat_i),
        .ack_o    (mem_ack),
        .dat_o    (mem_dat)
    );

endmodule

`default_nettype wire

//--- sim/wbsoc_assert.sv
// Bus protocol assertions for the subsystem top
// Ack is a single cycle pulse, follows a request and is low after reset
`timescale 1ns/10ps
`default_nettype none

module wbsoc_assert (
    input wire wb_clk_i,
    input wire wb_rst_i,
    input wire wbs_stb_i,
    input wire wbs_cyc_i,
    input wire wbs_ack_o
);

    // Failures seen so far, read by the testbench at the end
    int err_cnt = 0;

    // Single cycle ack
    ack_one_cycle: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_o |=> !wbs_ack_o
    ) else begin
        err_cnt = err_cnt + 1;
        $error("ack held high for two cycles");
    end

    // Ack answers a strobe of the previous cycle
    ack_after_req: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_o |-> $past(wbs_stb_i && wbs_cyc_i)
    ) else begin
        err_cnt = err_cnt + 1;
        $error("ack without a preceding strobe");
    end

    ack_low_after_reset: assert property (
        @(posedge wb_clk_i) $fell(wb_rst_i) |-> !wbs_ack_o
    ) else begin
        err_cnt = err_cnt + 1;
        $error("ack high when reset ends");
    end

endmodule

`default_nettype wire

//--- sim/tb_clkgen.sv
// Testbench clock and reset generator
// Free running clock and a synchronous reset held for a few cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
// Bus response checker
// Watches the top-level bus, measures ack latency and captures read
// data, then compares both against the expectation of each test
`timescale 1ns/10ps
`default_nettype none

module tb_checker
    import wbsoc_pkg::*;
(
    input  wire   wb_clk_i,
    input  wire   wb_rst_i,
    input  wire   wbs_stb_i,
    input  wire   wbs_cyc_i,
    input  wire   wbs_ack_i,
    input  word_t wbs_dat_i,
    output int    pass_cnt_o,
    output int    fail_cnt_o
);

    int    lat_cnt;
    int    ack_lat;
    word_t ack_dat;
    logic  seen_ack;

    initial begin
        pass_cnt_o = 0;
        fail_cnt_o = 0;
        lat_cnt    = 0;
        ack_lat    = 0;
        ack_dat    = '0;
        seen_ack   = 1'b0;
    end

    //------------------------------------------------------------
    // Bus monitor, sampled in the middle of the cycle
    //------------------------------------------------------------
    always @(negedge wb_clk_i) begin
        if (wb_rst_i) begin
            lat_cnt  = 0;
            seen_ack = 1'b0;
        end else if (wbs_ack_i) begin
            ack_lat  = lat_cnt;
            ack_dat  = wbs_dat_i;
            seen_ack = 1'b1;
            lat_cnt  = 0;
        end else if (wbs_stb_i && wbs_cyc_i) begin
            lat_cnt = lat_cnt + 1;
        end else begin
            lat_cnt = 0;
        end
    end

    // Forget the previous response before a new access
    task automatic clear_access();
        seen_ack = 1'b0;
    endtask

    //------------------------------------------------------------
    // Compare one finished test
    //------------------------------------------------------------
    task automatic check_access(input string name, input logic is_read,
                                input logic no_ack, input word_t exp_dat,
                                input int exp_lat);
        logic ok;
        ok = 1'b1;
        if (no_ack) begin
            if (seen_ack) begin
                $display("Error %s: unmapped access was acknowledged", name);
                ok = 1'b0;
            end
        end else if (!seen_ack) begin
            $display("Error %s: access got no ack", name);
            ok = 1'b0;
        end else if (ack_lat != exp_lat) begin
            $display("Error %s: ack latency expected %0d actual %0d",
                     name, exp_lat, ack_lat);
            ok = 1'b0;
        end else if (is_read && (ack_dat !== exp_dat)) begin
            $display("Error %s: expected %08h actual %08h", name, exp_dat, ack_dat);
            ok = 1'b0;
        end
        if (ok) begin
            $display("Pass  %s", name);
            pass_cnt_o = pass_cnt_o + 1;
        end else begin
            fail_cnt_o = fail_cnt_o + 1;
        end
    endtask

endmodule

`default_nettype wire

//--- sim/tb_top.sv
// Testbench top for the Wishbone sort and scratch memory subsystem
// Builds a table of bus accesses with expected results, applies it
// to the DUT and prints the closing summary
`timescale 1ns/10ps
`default_nettype none

`include "wbsoc_params.svh"

module tb_top
    import wbsoc_pkg::*;
();

    localparam int    TBL_LEN     = 64;
    localparam word_t LCG_SEED    = 32'h5e86;
    localparam int    TIMEOUT_CYC = TBL_LEN * 20 + 100;
    localparam int    ACK_WAIT    = 16;
    localparam int    NOACK_WAIT  = 8;
    localparam int    POLL_MAX    = 10;

    wire   wb_clk;
    wire   wb_rst;
    logic  stb_r;
    logic  cyc_r;
    logic  we_r;
    word_t adr_r;
    word_t dat_r;
    logic  ack;
    word_t rd_dat;
    int    pass_cnt;
    int    fail_cnt;
    int    cycle_cnt = 0;
    int    bad_cnt;

    //------------------------------------------------------------
    // Stimulus table and reference models
    //------------------------------------------------------------
    string tbl_name  [TBL_LEN];
    logic  tbl_we    [TBL_LEN];
    word_t tbl_adr   [TBL_LEN];
    word_t tbl_dat   [TBL_LEN];
    word_t tbl_exp   [TBL_LEN];
    int    tbl_lat   [TBL_LEN];
    logic  tbl_noack [TBL_LEN];
    logic  tbl_poll  [TBL_LEN];
    int    n_ent;

    word_t rnd_state;
    word_t mem_model    [`MEM_DEPTH];
    word_t slot_model   [`SORT_N];
    word_t sorted_model [`SORT_N];

    tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(4)) clkgen_i (
        .clk_o (wb_clk),
        .rst_o (wb_rst)
    );

    user_project_wrapper dut_i (
        .wb_clk_i  (wb_clk),
        .wb_rst_i  (wb_rst),
        .wbs_stb_i (stb_r),
        .wbs_cyc_i (cyc_r),
        .wbs_we_i  (we_r),
        .wbs_adr_i (adr_r),
        .wbs_dat_i (dat_r),
        .wbs_ack_o (ack),
        .wbs_dat_o (rd_dat)
    );

    tb_checker chk_i (
        .wb_clk_i   (wb_clk),
        .wb_rst_i   (wb_rst),
        .wbs_stb_i  (stb_r),
        .wbs_cyc_i  (cyc_r),
        .wbs_ack_i  (ack),
        .wbs_dat_i  (rd_dat),
        .pass_cnt_o (pass_cnt),
        .fail_cnt_o (fail_cnt)
    );

    bind user_project_wrapper wbsoc_assert proto_assert_i (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_ack_o (wbs_ack_o)
    );

    // LCG, one new word per call
    function word_t next_word();
        rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
        return rnd_state;
    endfunction

    function automatic word_t mem_addr(input int w);
        return {`WB_MEM_SEL, 24'(w * 4)};
    endfunction

    function automatic word_t sort_addr(input int ofs);
        return {`WB_SORT_SEL, 16'd0, 8'(ofs)};
    endfunction

    task automatic add_entry(input string name, input logic we, input word_t adr,
                             input word_t dat, input word_t exp, input logic noack,
                             input logic poll);
        tbl_name[n_ent]  = name;
        tbl_we[n_ent]    = we;
        tbl_adr[n_ent]   = adr;
        tbl_dat[n_ent]   = dat;
        tbl_exp[n_ent]   = exp;
        tbl_lat[n_ent]   = (adr[31:24] == `WB_MEM_SEL) ? `MEM_DELAY : 1;
        tbl_noack[n_ent] = noack;
        tbl_poll[n_ent]  = poll;
        n_ent = n_ent + 1;
    endtask

    // Ascending unsigned insertion sort of the slot model
    task automatic sort_reference();
        word_t t;
        int    j;
        for (int i = 0; i < `SORT_N; i++) begin
            sorted_model[i] = slot_model[i];
        end
        for (int i = 1; i < `SORT_N; i++) begin
            t = sorted_model[i];
            j = i - 1;
            while (j >= 0 && sorted_model[j] > t) begin
                sorted_model[j+1] = sorted_model[j];
                j = j - 1;
            end
            sorted_model[j+1] = t;
        end
    endtask

    // Start, poll until done, then read every result word
    task automatic queue_sort_run(input string tag);
        sort_reference();
        add_entry({tag, "_start"}, 1'b1, sort_addr(`SORT_CTRL_OFS), 32'd1, '0, 1'b0, 1'b0);
        add_entry({tag, "_busy"}, 1'b0, sort_addr(`SORT_CTRL_OFS), '0, 32'd0, 1'b0, 1'b0);
        add_entry({tag, "_done"}, 1'b0, sort_addr(`SORT_CTRL_OFS), '0, 32'd1, 1'b0, 1'b1);
        for (int k = 0; k < `SORT_N; k++) begin
            add_entry($sformatf("%s_res%0d", tag, k), 1'b0, sort_addr(`SORT_RES_OFS + 4 * k),
                      '0, sorted_model[k], 1'b0, 1'b0);
        end
    endtask

    task automatic build_table();
        word_t d;
        int    mem_idx [6];
        mem_idx = '{0, 1, 37, 128, 200, 255};
        for (int k = 0; k < 6; k++) begin
            d = next_word();
            mem_model[mem_idx[k]] = d;
            add_entry($sformatf("mem_wr%0d", k), 1'b1, mem_addr(mem_idx[k]), d, '0, 1'b0, 1'b0);
        end
        for (int k = 0; k < 6; k++) begin
            add_entry($sformatf("mem_rd%0d", k), 1'b0, mem_addr(mem_idx[k]), '0,
                      mem_model[mem_idx[k]], 1'b0, 1'b0);
        end
        // Word 256 + 5 lands on word 5
        d = next_word();
        add_entry("mem_alias_wr", 1'b1, mem_addr(256 + 5), d, '0, 1'b0, 1'b0);
        add_entry("mem_alias_rd", 1'b0, mem_addr(5), '0, d, 1'b0, 1'b0);
        // Slot 7 repeats slot 2
        for (int k = 0; k < `SORT_N; k++) begin
            slot_model[k] = (k == 7) ? slot_model[2] : next_word();
            add_entry($sformatf("slot_wr%0d", k), 1'b1, sort_addr(`SORT_SLOT_OFS + 4 * k),
                      slot_model[k], '0, 1'b0, 1'b0);
        end
        for (int k = 0; k < `SORT_N; k++) begin
            add_entry($sformatf("slot_rd%0d", k), 1'b0, sort_addr(`SORT_SLOT_OFS + 4 * k),
                      '0, slot_model[k], 1'b0, 1'b0);
        end
        queue_sort_run("sort1");
        // Rewrite one slot, done must drop
        slot_model[3] = next_word();
        add_entry("slot_rewr3", 1'b1, sort_addr(`SORT_SLOT_OFS + 12), slot_model[3], '0,
                  1'b0, 1'b0);
        add_entry("status_cleared", 1'b0, sort_addr(`SORT_CTRL_OFS), '0, 32'd0, 1'b0, 1'b0);
        queue_sort_run("sort2");
        add_entry("unmapped_rd", 1'b0, 32'h5500_0000, '0, '0, 1'b1, 1'b0);
        add_entry("unmapped_wr", 1'b1, 32'h0000_0010, next_word(), '0, 1'b1, 1'b0);
    endtask

    //------------------------------------------------------------
    // Bus driver
    //------------------------------------------------------------
    task automatic run_access(input int idx, output word_t rd);
        int waited;
        waited = 0;
        rd     = '0;
        @(posedge wb_clk);
        chk_i.clear_access();
        stb_r <= 1'b1;
        cyc_r <= 1'b1;
        we_r  <= tbl_we[idx];
        adr_r <= tbl_adr[idx];
        dat_r <= tbl_dat[idx];
        if (tbl_noack[idx]) begin
            repeat (NOACK_WAIT) @(negedge wb_clk);
        end else begin
            @(negedge wb_clk);
            while (!ack && waited < ACK_WAIT) begin
                waited = waited + 1;
                @(negedge wb_clk);
            end
            rd = rd_dat;
        end
        @(posedge wb_clk);
        stb_r <= 1'b0;
        cyc_r <= 1'b0;
        we_r  <= 1'b0;
    endtask

    // Polled entries repeat until the status reads nonzero
    task automatic apply_entry(input int idx);
        word_t rd;
        int    polls;
        run_access(idx, rd);
        polls = 1;
        while (tbl_poll[idx] && rd == '0 && polls < POLL_MAX) begin
            run_access(idx, rd);
            polls = polls + 1;
        end
        chk_i.check_access(tbl_name[idx], !tbl_we[idx], tbl_noack[idx], tbl_exp[idx],
                           tbl_lat[idx]);
    endtask

    always @(posedge wb_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        stb_r     = 1'b0;
        cyc_r     = 1'b0;
        we_r      = 1'b0;
        adr_r     = '0;
        dat_r     = '0;
        n_ent     = 0;
        rnd_state = LCG_SEED;
        build_table();
        @(negedge wb_rst);
        for (int i = 0; i < n_ent; i++) begin
            apply_entry(i);
        end
        repeat (2) @(posedge wb_clk);
        bad_cnt = fail_cnt + dut_i.proto_assert_i.err_cnt + (n_ent - pass_cnt - fail_cnt);
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
                 n_ent, pass_cnt, fail_cnt, dut_i.proto_assert_i.err_cnt);
        if (bad_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/wbsoc_pkg.sv
source/wb_bus_split.sv
sort/sort_network.sv
sort/sort_ctrl.sv
exmem/exmem_ram.sv
source/user_project_wrapper.sv
sim/wbsoc_assert.sv
sim/tb_clkgen.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f tb.f -Mdir "$BUILD_DIR" -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/tb_sim" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG_FILE"; then
    exit 0
fi
echo "Simulation did not pass, see $LOG_FILE"
exit 1
